//--- vlog.f
verilog/rom_ctrl_pkg.sv
verilog/rom_rd_if.sv
verilog/rom_ctrl_bus_stage.sv
verilog/rom_ctrl_checker.sv
verilog/rom_ctrl_mux.sv
verilog/rom_ctrl_scr_rom.sv
verilog/rom_ctrl_top.sv
verif/rom_ctrl_assertions.sv
verif/rom_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the ROM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module rom_ctrl_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/Vrom_ctrl_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

//--- verif/rom_ctrl_tb.sv
/*
  ROM controller testbench
  Clock and reset, random credit-based reads, host model, compare tasks, watchdog
*/

`timescale 1ns/1ps

module rom_ctrl_tb;

  localparam int                   AddrWidth   = 6;
  localparam int                   DataWidth   = 32;
  localparam int                   NumCredits  = 4;
  localparam logic [DataWidth-1:0] DataKey     = 32'h3c5a_96e1;
  localparam logic [AddrWidth-1:0] AddrKey     = 6'h15;
  localparam int                   Depth       = 2 ** AddrWidth;
  localparam int                   NumReads    = 40;
  localparam int                   ClkPeriod   = 100;
  // Checker walk plus 8 cycles per bus read over both read tests, doubled as margin
  localparam int                   WatchCycles = 2 * (Depth + 16 + 8 * 2 * NumReads);

  logic                 clk_i;
  logic                 rst_ni;
  logic                 bus_req_i;
  logic [AddrWidth-1:0] bus_addr_i;
  logic                 bus_credit_o;
  logic                 bus_rvalid_o;
  logic [DataWidth-1:0] bus_rdata_o;
  logic                 bus_rready_i;
  logic                 check_done_o;
  logic                 check_fail_o;
  logic                 alert_o;

  integer               seed;
  int                   errors;
  int                   tests_run;
  int                   tests_failed;
  int                   test_errors;
  // Credits the host holds right now
  int                   host_credits;
  logic                 alert_seen;
  // Expected clear data, oldest request first
  logic [DataWidth-1:0] exp_q [$];

  rom_ctrl_top #(
    .AddrWidth  (AddrWidth),
    .DataWidth  (DataWidth),
    .NumCredits (NumCredits),
    .DataKey    (DataKey),
    .AddrKey    (AddrKey)
  ) u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bus_req_i    (bus_req_i),
    .bus_addr_i   (bus_addr_i),
    .bus_credit_o (bus_credit_o),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rdata_o  (bus_rdata_o),
    .bus_rready_i (bus_rready_i),
    .check_done_o (check_done_o),
    .check_fail_o (check_fail_o),
    .alert_o      (alert_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic check_data(string name, logic [DataWidth-1:0] got, logic [DataWidth-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 'h%h, expected 'h%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error: %s = 'h%h, expected 'h%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic report_problem(string msg);
    $display("Problem: %s at %0t", msg, $time);
    errors++;
  endtask

  task automatic open_test();
    test_errors = errors;
  endtask

  task automatic close_test(string name);
    tests_run++;
    if (errors != test_errors) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - test_errors);
    end else begin
      $display("test %s: passed", name);
    end
  endtask

  // Inputs change just after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Host side model, sampled mid-cycle
  // Response first, then request, then credit, matching what the coming edge sees
  always @(negedge clk_i) begin
    if (rst_ni) begin
      alert_seen = alert_seen | alert_o;
      if (bus_rvalid_o && exp_q.size() == 0) begin
        report_problem("response valid with no read outstanding");
      end else if (bus_rvalid_o && bus_rready_i) begin
        check_data("bus_rdata_o", bus_rdata_o, exp_q.pop_front());
      end
      if (bus_req_i) begin
        if (host_credits == 0) begin
          report_problem("request sent while holding no credit");
        end else begin
          host_credits--;
        end
        exp_q.push_back(rom_ctrl_pkg::rom_clear_word(32'(bus_addr_i), Depth, DataKey));
      end
      if (bus_credit_o) begin
        host_credits++;
        if (host_credits > NumCredits) begin
          report_problem("more credits received than the pipeline can hold");
        end
      end
    end
  end

  // Random reads, spending credits as they come, then drain
  task automatic run_reads(int n, logic random_ready);
    logic [31:0] r;
    int          issued;
    issued = 0;
    // A request driven this cycle reaches the queue only at the next falling edge
    while (issued < n || bus_req_i || exp_q.size() != 0) begin
      next_cycle();
      r            = $random(seed);
      bus_rready_i = random_ready ? r[0] : 1'b1;
      bus_req_i    = 1'b0;
      if (issued < n && host_credits > 0 && r[2:1] != 2'b00) begin
        bus_req_i  = 1'b1;
        bus_addr_i = r[AddrWidth+7:8];
        issued++;
      end
    end
    bus_req_i    = 1'b0;
    bus_rready_i = 1'b1;
    // Last acceptance returns its credit one cycle later
    repeat (3) next_cycle();
    check_flag("bus_rvalid_o", bus_rvalid_o, 1'b0);
    if (host_credits != NumCredits) begin
      report_problem($sformatf("host holds %0d credits after draining, expected %0d",
                               host_credits, NumCredits));
    end
  endtask

  initial begin : main
    logic [DataWidth-1:0] sum;
    seed         = 32'hbbc7_3322;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    host_credits = 0;
    alert_seen   = 1'b0;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    bus_req_i    = 1'b0;
    bus_addr_i   = '0;
    bus_rready_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Boot check against the digest sum rule
    open_test();
    check_flag("bus_credit_o", bus_credit_o, 1'b0);
    check_flag("bus_rvalid_o", bus_rvalid_o, 1'b0);
    check_flag("check_done_o", check_done_o, 1'b0);
    check_flag("check_fail_o", check_fail_o, 1'b0);
    sum = '0;
    for (int i = 0; i < Depth - 1; i++) begin
      sum += rom_ctrl_pkg::rom_clear_word(i, Depth, DataKey) ^
             rom_ctrl_pkg::rom_keystream(i, DataKey);
    end
    check_data("digest", rom_ctrl_pkg::rom_clear_word(Depth - 1, Depth, DataKey), sum);
    while (!check_done_o) begin
      next_cycle();
    end
    check_flag("check_fail_o", check_fail_o, 1'b0);
    close_test("boot_check");

    // Initial credit burst with no requests
    open_test();
    if (host_credits != 0) begin
      report_problem("credits arrived before the boot check finished");
    end
    repeat (NumCredits + 4) next_cycle();
    if (host_credits != NumCredits) begin
      report_problem($sformatf("received %0d initial credits, expected %0d",
                               host_credits, NumCredits));
    end
    close_test("initial_credits");

    open_test();
    run_reads(NumReads, 1'b0);
    close_test("in_order_reads");

    open_test();
    run_reads(NumReads, 1'b1);
    close_test("backpressure_reads");

    // Handover is permanent and quiet
    open_test();
    check_flag("check_done_o", check_done_o, 1'b1);
    check_flag("bus_gnt", u_dut.bus_gnt, 1'b1);
    check_flag("alert_o", alert_seen, 1'b0);
    close_test("handover_hold");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WatchCycles * ClkPeriod);
    $display("Timeout: run did not complete within %0d cycles", WatchCycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- verif/rom_ctrl_assertions.sv
/*
  Concurrent checks on the ROM controller top level
  Alert, credit bound and response hold under back-pressure
*/

`timescale 1ns/1ps

module rom_ctrl_assertions #(
  parameter int NumCredits = 4
) (
  input logic clk_i,
  input logic rst_ni,
  input logic bus_credit_o,
  input logic bus_rvalid_o,
  input logic bus_rready_i,
  input logic alert_o
);

  // Credits handed out and not yet returned by an accepted response
  int outstanding_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + int'(bus_credit_o) - int'(bus_rvalid_o && bus_rready_i);
    end
  end

  no_alert_a: assert property (@(posedge clk_i) disable iff (!rst_ni) !alert_o)
    else $error("alert_o raised");

  credit_bound_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                   outstanding_q <= NumCredits)
    else $error("outstanding credits %0d above limit", outstanding_q);

  // A held response stays until taken
  rvalid_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                  bus_rvalid_o && !bus_rready_i |=> bus_rvalid_o)
    else $error("bus_rvalid_o dropped without acceptance");

endmodule

bind rom_ctrl_top rom_ctrl_assertions #(
  .NumCredits (NumCredits)
) u_assertions (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .bus_credit_o (bus_credit_o),
  .bus_rvalid_o (bus_rvalid_o),
  .bus_rready_i (bus_rready_i),
  .alert_o      (alert_o)
);

//--- verilog/rom_ctrl_top.sv
/*
  ROM controller top level
  Checker and bus stage feed the one-way mux, which drives the scrambled ROM
*/

`timescale 1ns/1ps

module rom_ctrl_top #(
  parameter int                   AddrWidth  = rom_ctrl_pkg::AddrWidth,
  parameter int                   DataWidth  = rom_ctrl_pkg::DataWidth,
  parameter int                   NumCredits = 4,
  parameter logic [DataWidth-1:0] DataKey    = DataWidth'(32'h3c5a_96e1),
  parameter logic [AddrWidth-1:0] AddrKey    = AddrWidth'(6'h15)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Host side, requests need a credit
  input  logic                 bus_req_i,
  input  logic [AddrWidth-1:0] bus_addr_i,
  output logic                 bus_credit_o,
  output logic                 bus_rvalid_o,
  output logic [DataWidth-1:0] bus_rdata_o,
  input  logic                 bus_rready_i,
  // Boot check status
  output logic                 check_done_o,
  output logic                 check_fail_o,
  output logic                 alert_o
);

  rom_ctrl_pkg::mubi4_e sel_bus;
  logic                 bus_gnt;

  rom_rd_if #(.AddrWidth(AddrWidth), .DataWidth(DataWidth)) chk_rd ();
  rom_rd_if #(.AddrWidth(AddrWidth), .DataWidth(DataWidth)) bus_rd ();
  rom_rd_if #(.AddrWidth(AddrWidth), .DataWidth(DataWidth)) rom_rd ();

  rom_ctrl_checker #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth),
    .DataKey   (DataKey)
  ) u_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd           (chk_rd),
    .sel_bus_o    (sel_bus),
    .check_done_o (check_done_o),
    .check_fail_o (check_fail_o)
  );

  rom_ctrl_bus_stage #(
    .AddrWidth  (AddrWidth),
    .DataWidth  (DataWidth),
    .NumCredits (NumCredits),
    .AddrKey    (AddrKey)
  ) u_bus_stage (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bus_gnt_i    (bus_gnt),
    .bus_req_i    (bus_req_i),
    .bus_addr_i   (bus_addr_i),
    .bus_credit_o (bus_credit_o),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rdata_o  (bus_rdata_o),
    .bus_rready_i (bus_rready_i),
    .rd           (bus_rd)
  );

  rom_ctrl_mux #(
    .DataWidth (DataWidth)
  ) u_mux (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .sel_bus_i (sel_bus),
    .bus_gnt_o (bus_gnt),
    .chk       (chk_rd),
    .bus       (bus_rd),
    .rom       (rom_rd),
    .alert_o   (alert_o)
  );

  rom_ctrl_scr_rom #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth),
    .DataKey   (DataKey),
    .AddrKey   (AddrKey)
  ) u_scr_rom (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .rd     (rom_rd)
  );

endmodule

//--- verilog/rom_ctrl_scr_rom.sv
/*
  Scrambled ROM array
  Image built at elaboration, one-cycle read, descrambled output
*/

`timescale 1ns/1ps

module rom_ctrl_scr_rom #(
  parameter int                   AddrWidth = rom_ctrl_pkg::AddrWidth,
  parameter int                   DataWidth = rom_ctrl_pkg::DataWidth,
  parameter logic [DataWidth-1:0] DataKey   = '0,
  parameter logic [AddrWidth-1:0] AddrKey   = '0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  rom_rd_if.rom_side rd
);

  localparam int Depth = 2 ** AddrWidth;

  logic [DataWidth-1:0] mem [Depth];
  logic [DataWidth-1:0] scr_q;
  // Logical address of the word in scr_q
  logic [AddrWidth-1:0] laddr_q;
  logic                 rvalid_q;

  // Physical slot p holds the logical word that maps onto it
  // The permutation is its own inverse
  for (genvar p = 0; p < Depth; p++) begin : g_image
    localparam int unsigned LogAddr = rom_ctrl_pkg::rom_addr_perm(p, 32'(AddrKey), Depth);
    localparam logic [DataWidth-1:0] ScrWord =
        rom_ctrl_pkg::rom_clear_word(LogAddr, Depth, DataKey) ^
        rom_ctrl_pkg::rom_keystream(LogAddr, DataKey);
    assign mem[p] = ScrWord;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd.req) begin
      scr_q   <= mem[rd.rom_addr];
      laddr_q <= rd.prince_addr;
    end
  end

  assign rd.scr_rdata = scr_q;
  // Descramble with the keystream of the logical address
  assign rd.clr_rdata = scr_q ^ rom_ctrl_pkg::rom_keystream(32'(laddr_q), DataKey);
  assign rd.rvalid    = rvalid_q;

endmodule

//--- verilog/rom_ctrl_mux.sv
/*
  One-way mux between checker and bus in front of the ROM
  Registered select, integrity and reversion alert
*/

`timescale 1ns/1ps

module rom_ctrl_mux #(
  parameter int DataWidth = rom_ctrl_pkg::DataWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  rom_ctrl_pkg::mubi4_e sel_bus_i,
  output logic                 bus_gnt_o,
  rom_rd_if.rom_side           chk,
  rom_rd_if.rom_side           bus,
  rom_rd_if.requester          rom,
  output logic                 alert_o
);

  rom_ctrl_pkg::mubi4_e sel_d;
  rom_ctrl_pkg::mubi4_e sel_q;
  // One cycle behind sel_q, catches a flop that falls back
  rom_ctrl_pkg::mubi4_e sel_qq;
  logic                 sel_true_i;
  logic                 sel_true_q;
  logic                 sel_invalid;
  logic                 sel_reverted;
  logic                 sel_q_reverted;
  logic                 alert_q;

  assign sel_true_i = rom_ctrl_pkg::mubi4_is_true(sel_bus_i);
  assign sel_true_q = rom_ctrl_pkg::mubi4_is_true(sel_q);

  // Once true the registered select holds true, whatever the input does
  assign sel_d = sel_true_q ? rom_ctrl_pkg::MuBi4True : sel_bus_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q  <= rom_ctrl_pkg::MuBi4False;
      sel_qq <= rom_ctrl_pkg::MuBi4False;
    end else begin
      sel_q  <= sel_d;
      sel_qq <= sel_q;
    end
  end

  // Corrupt encoding on the input or in the flop
  assign sel_invalid = rom_ctrl_pkg::mubi4_is_invalid(sel_bus_i) ||
                       rom_ctrl_pkg::mubi4_is_invalid(sel_q);

  // Input went back to the checker after handover
  assign sel_reverted = sel_true_q && rom_ctrl_pkg::mubi4_is_false(sel_bus_i);

  // Registered copy lost its true value
  assign sel_q_reverted = rom_ctrl_pkg::mubi4_is_true(sel_qq) && !sel_true_q;

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else if (sel_invalid || sel_reverted || sel_q_reverted) begin
      alert_q <= 1'b1;
    end
  end

  assign alert_o = alert_q;

  // Bus owns the ROM from the cycle the select turns true
  assign bus_gnt_o = sel_true_i;

  assign rom.req         = sel_true_i ? bus.req         : chk.req;
  assign rom.rom_addr    = sel_true_i ? bus.rom_addr    : chk.rom_addr;
  assign rom.prince_addr = sel_true_i ? bus.prince_addr : chk.prince_addr;

  // A response belongs to whoever held the select at request time
  assign bus.rvalid    = sel_true_q && rom.rvalid;
  assign bus.clr_rdata = rom.clr_rdata;
  // Bus never sees raw scrambled words
  assign bus.scr_rdata = {DataWidth{1'b0}};

  assign chk.rvalid    = !sel_true_q && rom.rvalid;
  assign chk.scr_rdata = rom.scr_rdata;
  // Checker path carries only scrambled data
  assign chk.clr_rdata = {DataWidth{1'b0}};

endmodule

//--- verilog/rom_ctrl_checker.sv
/*
  Boot-time ROM checker
  Reads every word, sums the scrambled image and compares with the stored digest
  Hands the ROM to the bus on a match
*/

`timescale 1ns/1ps

module rom_ctrl_checker #(
  parameter int                   AddrWidth = rom_ctrl_pkg::AddrWidth,
  parameter int                   DataWidth = rom_ctrl_pkg::DataWidth,
  parameter logic [DataWidth-1:0] DataKey   = '0
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  rom_rd_if.requester          rd,
  output rom_ctrl_pkg::mubi4_e sel_bus_o,
  output logic                 check_done_o,
  output logic                 check_fail_o
);

  localparam int                   Depth    = 2 ** AddrWidth;
  localparam logic [AddrWidth-1:0] LastAddr = AddrWidth'(Depth - 1);
  // Keystream of the digest slot, needed to unscramble it
  localparam logic [DataWidth-1:0] DigestKs = rom_ctrl_pkg::rom_keystream(Depth - 1, DataKey);

  rom_ctrl_pkg::chk_state_e state_q;
  rom_ctrl_pkg::chk_state_e state_d;
  logic [AddrWidth-1:0]     req_addr_q;
  logic [AddrWidth-1:0]     rsp_addr_q;
  logic                     req_done_q;
  logic                     last_rsp;
  logic [DataWidth-1:0]     sum_q;
  logic [DataWidth-1:0]     digest_q;

  // One read per cycle, physical and logical address the same
  assign rd.req         = (state_q == rom_ctrl_pkg::ChkRead) && !req_done_q;
  assign rd.rom_addr    = req_addr_q;
  assign rd.prince_addr = req_addr_q;

  // Responses come back in order, so a counter names each one
  assign last_rsp = rd.rvalid && (rsp_addr_q == LastAddr);

  always_comb begin
    state_d = state_q;
    case (state_q)
      rom_ctrl_pkg::ChkIdle: begin
        state_d = rom_ctrl_pkg::ChkRead;
      end
      rom_ctrl_pkg::ChkRead: begin
        if (last_rsp) begin
          state_d = rom_ctrl_pkg::ChkCompare;
        end
      end
      rom_ctrl_pkg::ChkCompare: begin
        state_d = (sum_q == digest_q) ? rom_ctrl_pkg::ChkDone : rom_ctrl_pkg::ChkFail;
      end
      // Done and fail are terminal
      default: begin
        state_d = state_q;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= rom_ctrl_pkg::ChkIdle;
      req_addr_q <= '0;
      rsp_addr_q <= '0;
      req_done_q <= 1'b0;
      sum_q      <= '0;
    end else begin
      state_q <= state_d;
      if (rd.req) begin
        req_addr_q <= req_addr_q + 1'b1;
        if (req_addr_q == LastAddr) begin
          req_done_q <= 1'b1;
        end
      end
      if (rd.rvalid) begin
        rsp_addr_q <= rsp_addr_q + 1'b1;
        // Digest word itself stays out of the sum
        if (!last_rsp) begin
          sum_q <= sum_q + rd.scr_rdata;
        end
      end
    end
  end

  // Digest in clear form, captured from the last response
  always_ff @(posedge clk_i) begin
    if (last_rsp) begin
      digest_q <= rd.scr_rdata ^ DigestKs;
    end
  end

  // Select only moves to the bus on a good digest
  assign sel_bus_o = (state_q == rom_ctrl_pkg::ChkDone) ? rom_ctrl_pkg::MuBi4True
                                                        : rom_ctrl_pkg::MuBi4False;

  assign check_done_o = (state_q == rom_ctrl_pkg::ChkDone) ||
                        (state_q == rom_ctrl_pkg::ChkFail);
  assign check_fail_o = state_q == rom_ctrl_pkg::ChkFail;

endmodule

//--- verilog/rom_ctrl_bus_stage.sv
/*
  Bus request stage
  Credit issue and return, address permutation, in-order response FIFO
*/

`timescale 1ns/1ps

module rom_ctrl_bus_stage #(
  parameter int                   AddrWidth  = rom_ctrl_pkg::AddrWidth,
  parameter int                   DataWidth  = rom_ctrl_pkg::DataWidth,
  parameter int                   NumCredits = 4,
  parameter logic [AddrWidth-1:0] AddrKey    = '0
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 bus_gnt_i,
  input  logic                 bus_req_i,
  input  logic [AddrWidth-1:0] bus_addr_i,
  output logic                 bus_credit_o,
  output logic                 bus_rvalid_o,
  output logic [DataWidth-1:0] bus_rdata_o,
  input  logic                 bus_rready_i,
  rom_rd_if.requester          rd
);

  localparam int Depth = 2 ** AddrWidth;
  localparam int CntW  = $clog2(NumCredits + 1);
  localparam int PtrW  = (NumCredits > 1) ? $clog2(NumCredits) : 1;

  logic [CntW-1:0]      init_q;
  logic [CntW-1:0]      owed_q;
  logic [CntW-1:0]      owed_sum;
  logic                 issue_init;
  logic                 credit_q;
  logic                 push;
  logic                 pop;
  logic [PtrW-1:0]      wr_ptr_q;
  logic [PtrW-1:0]      rd_ptr_q;
  logic [CntW-1:0]      count_q;
  logic [DataWidth-1:0] fifo_q [NumCredits];

  // Wrap at the FIFO depth, which need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] p);
    return (p == PtrW'(NumCredits - 1)) ? '0 : p + 1'b1;
  endfunction

  // Requests go straight to the mux, credits already bound them
  assign rd.req         = bus_req_i;
  assign rd.prince_addr = bus_addr_i;
  assign rd.rom_addr    = AddrWidth'(rom_ctrl_pkg::rom_addr_perm(32'(bus_addr_i),
                                                                 32'(AddrKey), Depth));

  assign push = rd.rvalid;
  assign pop  = bus_rvalid_o && bus_rready_i;

  // Initial credits once the bus owns the ROM, one per cycle
  assign issue_init = bus_gnt_i && (init_q != CntW'(NumCredits));
  // Returned credits waiting for a free credit slot
  assign owed_sum   = owed_q + CntW'(pop);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_q   <= '0;
      owed_q   <= '0;
      credit_q <= 1'b0;
    end else begin
      credit_q <= issue_init || (owed_sum != '0);
      if (issue_init) begin
        init_q <= init_q + 1'b1;
      end
      // An initial credit takes the pulse slot, owed ones wait
      owed_q <= (issue_init || owed_sum == '0) ? owed_sum : owed_sum - 1'b1;
    end
  end

  // FIFO control
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + CntW'(push) - CntW'(pop);
    end
  end

  // FIFO storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= rd.clr_rdata;
    end
  end

  assign bus_credit_o = credit_q;
  assign bus_rvalid_o = count_q != '0;
  assign bus_rdata_o  = fifo_q[rd_ptr_q];

endmodule

//--- verilog/rom_rd_if.sv
/*
  ROM read port
  Requester drives request and both addresses, ROM side returns data and valid
*/

`timescale 1ns/1ps

interface rom_rd_if #(
  parameter int AddrWidth = rom_ctrl_pkg::AddrWidth,
  parameter int DataWidth = rom_ctrl_pkg::DataWidth
);

  logic                 req;
  // Physical array index
  logic [AddrWidth-1:0] rom_addr;
  // Logical address, selects the keystream
  logic [AddrWidth-1:0] prince_addr;
  logic [DataWidth-1:0] scr_rdata;
  logic [DataWidth-1:0] clr_rdata;
  logic                 rvalid;

  modport requester (output req, rom_addr, prince_addr, input scr_rdata, clr_rdata, rvalid);

  modport rom_side (input req, rom_addr, prince_addr, output scr_rdata, clr_rdata, rvalid);

endinterface

//--- verilog/rom_ctrl_pkg.sv
/*
  Shared definitions for the ROM controller
  Select encoding, checker states, default widths, scrambling and select helpers
*/

package rom_ctrl_pkg;

  // Default geometry
  parameter int AddrWidth = 6;
  parameter int DataWidth = 32;

  // Four-bit encoded select, every other pattern is a fault
  typedef enum logic [3:0] {
    MuBi4True  = 4'h6,
    MuBi4False = 4'h9
  } mubi4_e;

  // Checker FSM
  typedef enum logic [2:0] {
    ChkIdle,
    ChkRead,
    ChkCompare,
    ChkDone,
    ChkFail
  } chk_state_e;

  // Keystream word for a logical address
  function automatic logic [DataWidth-1:0] rom_keystream(int unsigned addr,
                                                         logic [DataWidth-1:0] key);
    logic [DataWidth-1:0] ks;
    ks = key ^ DataWidth'(addr * 32'h9e37_79b1);
    // Rotate and fold so neighbouring addresses differ in many bits
    return ks ^ {ks[DataWidth-9:0], ks[DataWidth-1:DataWidth-8]};
  endfunction

  // Logical to physical address, XOR with the key
  // The digest slot and its XOR partner stay in place so the top word is still the digest
  function automatic int unsigned rom_addr_perm(int unsigned addr, int unsigned key,
                                                int unsigned depth);
    int unsigned last;
    int unsigned k;
    last = depth - 1;
    k    = key & last;
    if (addr == last || addr == (last ^ k)) begin
      return addr;
    end
    return addr ^ k;
  endfunction

  // Address mixing for the cleartext image
  function automatic logic [DataWidth-1:0] rom_mix(int unsigned addr);
    int unsigned m;
    m = addr * 32'h045d_9f3b;
    return DataWidth'(m ^ (m >> 15) ^ 32'hc3a5_0f1e);
  endfunction

  // Cleartext image, top word is the sum of all other scrambled words
  function automatic logic [DataWidth-1:0] rom_clear_word(int unsigned addr, int unsigned depth,
                                                          logic [DataWidth-1:0] data_key);
    logic [DataWidth-1:0] sum;
    sum = '0;
    if (addr != depth - 1) begin
      return rom_mix(addr);
    end
    for (int unsigned i = 0; i < depth - 1; i++) begin
      sum += rom_mix(i) ^ rom_keystream(i, data_key);
    end
    return sum;
  endfunction

  // Strict select tests
  function automatic logic mubi4_is_true(mubi4_e v);
    return v == MuBi4True;
  endfunction

  function automatic logic mubi4_is_false(mubi4_e v);
    return v == MuBi4False;
  endfunction

  function automatic logic mubi4_is_invalid(mubi4_e v);
    return !(mubi4_is_true(v) || mubi4_is_false(v));
  endfunction

endpackage
